/* hw/smc_ahb_pkg.sv */
/*
 * AHB-lite side definitions for the static memory controller
 * Address and data word types, transfer type and size encodings,
 * byte lane type and the lane selection function
 */

package smc_ahb_pkg;

  typedef logic [31:0] ahb_addr_t;  // Byte address
  typedef logic [31:0] ahb_data_t;  // One data word
  typedef logic [3:0]  byte_lanes_t; // One bit per byte lane, active high

  // Transfer type as driven by the master
  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_BUSY   = 2'b01,
    HTRANS_NONSEQ = 2'b10,
    HTRANS_SEQ    = 2'b11
  } htrans_e;

  // Only sizes up to one word are served
  typedef enum logic [2:0] {
    HSIZE_BYTE = 3'b000,
    HSIZE_HALF = 3'b001,
    HSIZE_WORD = 3'b010
  } hsize_e;

  // Active lanes from low address bits and transfer size
  function automatic byte_lanes_t lanes_of(input logic [1:0] addr_lo, input hsize_e size);
    byte_lanes_t lanes;
    case (size)
      HSIZE_BYTE: lanes = byte_lanes_t'(4'b0001 << addr_lo);   // Lane picked by addr_lo
      HSIZE_HALF: lanes = addr_lo[1] ? 4'b1100 : 4'b0011;      // Upper or lower half
      default:    lanes = 4'b1111;                             // Full word
    endcase
    return lanes;
  endfunction

endpackage

/* hw/smc_emi_pkg.sv */
/*
 * External memory interface definitions
 * Access phase encoding, timing counter width and
 * the external address, data and lane widths
 */

package smc_emi_pkg;

  // Phases of one external access
  typedef enum logic [1:0] {
    PH_IDLE   = 2'b00,  // No access, chip select high
    PH_LEAD   = 2'b01,  // Chip select lead time
    PH_STROBE = 2'b10,  // Wait state window, strobes active
    PH_TRAIL  = 2'b11   // Chip select trail time
  } smc_phase_e;

  // Timing counter width, covers up to 255 wait states
  localparam int TIMING_CNT_W = 8;

  //--------------------------------------------------------------------
  // External bus widths
  //--------------------------------------------------------------------
  localparam int EMI_ADDR_W = 32;
  localparam int EMI_DATA_W = 32;              // As wide as a word transfer
  localparam int EMI_LANES  = EMI_DATA_W / 8;

  typedef logic [EMI_ADDR_W-1:0] emi_addr_t;
  typedef logic [EMI_DATA_W-1:0] emi_data_t;
  typedef logic [EMI_LANES-1:0]  emi_lanes_t;  // Per-lane strobes and enables

endpackage

/* hw/smc_ahb_slave.sv */
/*
 * AHB-lite slave front end
 * Address phase decode and capture, write data capture,
 * hready generation and read data return
 */

`timescale 1ns/1ps

module smc_ahb_slave (
  input  logic                     hclk,
  input  logic                     arst_n,
  // AHB-lite address and data phase
  input  logic                     hsel,
  input  smc_ahb_pkg::htrans_e     htrans,
  input  smc_ahb_pkg::ahb_addr_t   haddr,
  input  logic                     hwrite,
  input  smc_ahb_pkg::hsize_e      hsize,
  input  smc_ahb_pkg::ahb_data_t   hwdata,
  input  logic                     hready,       // Muxed bus ready
  output logic                     smc_hready,
  output smc_ahb_pkg::ahb_data_t   smc_hrdata,
  // Access FSM and external side
  input  logic                     done,         // Last cycle of the access
  input  smc_emi_pkg::emi_data_t   rdata,        // Captured read word
  output logic                     start,        // One-cycle access request
  output logic                     wr,           // Held for whole access
  output smc_ahb_pkg::ahb_addr_t   acc_addr,
  output smc_ahb_pkg::byte_lanes_t acc_lanes,
  output smc_ahb_pkg::ahb_data_t   acc_wdata
);

  import smc_ahb_pkg::*;

  logic accept;      // Valid address phase this cycle
  logic wdata_phase; // First data phase cycle of a write

  // NONSEQ and SEQ both start a transfer, IDLE and BUSY are ignored
  assign accept = hsel && hready &&
                  ((htrans == HTRANS_NONSEQ) || (htrans == HTRANS_SEQ));

  //--------------------------------------------------------------------
  // Address phase
  //--------------------------------------------------------------------
  always_ff @(posedge hclk or negedge arst_n) begin
    if (!arst_n) begin
      start       <= 1'b0;
      wr          <= 1'b0;
      wdata_phase <= 1'b0;
    end else begin
      start       <= accept;             // FSM kicks off next cycle
      wdata_phase <= accept && hwrite;
      if (accept) begin
        wr <= hwrite;                    // Direction for the whole access
      end
    end
  end

  // Address and lanes of the accepted transfer
  always_ff @(posedge hclk) begin
    if (accept) begin
      acc_addr  <= haddr;
      acc_lanes <= lanes_of(haddr[1:0], hsize);
    end
  end

  // Write data arrives one cycle after its address
  always_ff @(posedge hclk) begin
    if (wdata_phase) begin
      acc_wdata <= hwdata;
    end
  end

  //--------------------------------------------------------------------
  // Ready and read data
  //--------------------------------------------------------------------
  // Low from the cycle after acceptance up to and including done
  always_ff @(posedge hclk or negedge arst_n) begin
    if (!arst_n) begin
      smc_hready <= 1'b1;
    end else if (done) begin
      smc_hready <= 1'b1;                // Rises with valid rdata
    end else if (accept) begin
      smc_hready <= 1'b0;
    end
  end

  // Read word is held by the emi side until the next capture
  assign smc_hrdata = rdata;

endmodule

/* hw/smc_access_fsm.sv */
/*
 * Access phase sequencer
 * IDLE, LEAD, STROBE, TRAIL state machine with one reloadable
 * down-counter and the end-of-access pulse
 */

`timescale 1ns/1ps

module smc_access_fsm #(
  parameter int unsigned CSLE_CYCLES = 1,  // Chip select lead, 0 to 3
  parameter int unsigned WS_CYCLES   = 2,  // Wait states, strobe is one longer
  parameter int unsigned CSTE_CYCLES = 1   // Chip select trail, 0 to 3
) (
  input  logic                    hclk,
  input  logic                    arst_n,
  input  logic                    start,   // Pulse from the slave
  output smc_emi_pkg::smc_phase_e phase,
  output logic                    done     // Final cycle of the access
);

  import smc_emi_pkg::*;

  // Counter reload values, count runs down to zero
  localparam logic [TIMING_CNT_W-1:0] LEAD_LOAD =
    TIMING_CNT_W'((CSLE_CYCLES > 0) ? CSLE_CYCLES - 1 : 0);
  localparam logic [TIMING_CNT_W-1:0] STROBE_LOAD =
    TIMING_CNT_W'(WS_CYCLES);                       // WS_CYCLES+1 cycles
  localparam logic [TIMING_CNT_W-1:0] TRAIL_LOAD =
    TIMING_CNT_W'((CSTE_CYCLES > 0) ? CSTE_CYCLES - 1 : 0);

  smc_phase_e              phase_d;
  logic [TIMING_CNT_W-1:0] cnt;        // Cycles left in current phase
  logic [TIMING_CNT_W-1:0] cnt_d;
  logic                    cnt_zero;

  assign cnt_zero = (cnt == '0);

  //--------------------------------------------------------------------
  // Next phase and counter
  //--------------------------------------------------------------------
  always_comb begin
    phase_d = phase;
    cnt_d   = cnt_zero ? cnt : cnt - 1'b1;   // Free running down to zero
    unique case (phase)
      PH_IDLE: begin
        if (start) begin
          if (CSLE_CYCLES > 0) begin
            phase_d = PH_LEAD;
            cnt_d   = LEAD_LOAD;
          end else begin
            phase_d = PH_STROBE;             // No lead time
            cnt_d   = STROBE_LOAD;
          end
        end
      end
      PH_LEAD: begin
        if (cnt_zero) begin
          phase_d = PH_STROBE;
          cnt_d   = STROBE_LOAD;
        end
      end
      PH_STROBE: begin
        if (cnt_zero) begin
          if (CSTE_CYCLES > 0) begin
            phase_d = PH_TRAIL;
            cnt_d   = TRAIL_LOAD;
          end else begin
            phase_d = PH_IDLE;               // No trail time
          end
        end
      end
      PH_TRAIL: begin
        if (cnt_zero) begin
          phase_d = PH_IDLE;
        end
      end
      default: begin
        phase_d = PH_IDLE;
      end
    endcase
  end

  always_ff @(posedge hclk or negedge arst_n) begin
    if (!arst_n) begin
      phase <= PH_IDLE;
      cnt   <= '0;
    end else begin
      phase <= phase_d;
      cnt   <= cnt_d;
    end
  end

  //--------------------------------------------------------------------
  // End of access
  //--------------------------------------------------------------------
  // Last TRAIL cycle, or last STROBE cycle when trail is skipped
  always_comb begin
    if (CSTE_CYCLES > 0) begin
      done = (phase == PH_TRAIL) && cnt_zero;
    end else begin
      done = (phase == PH_STROBE) && cnt_zero;
    end
  end

endmodule

/* hw/smc_emi_drive.sv */
/*
 * External memory interface drivers
 * Registered chip select, read and write strobes, byte enables,
 * address, write data, output enable and read data capture
 */

`timescale 1ns/1ps

module smc_emi_drive (
  input  logic                     hclk,
  input  logic                     arst_n,
  input  smc_emi_pkg::smc_phase_e  phase,
  input  logic                     done,
  input  logic                     wr,
  input  smc_ahb_pkg::ahb_addr_t   acc_addr,
  input  smc_ahb_pkg::byte_lanes_t acc_lanes,
  input  smc_ahb_pkg::ahb_data_t   acc_wdata,
  input  smc_emi_pkg::emi_data_t   data_smc,     // Read data from memory
  output smc_emi_pkg::emi_addr_t   smc_addr,
  output smc_emi_pkg::emi_data_t   smc_data,
  output logic                     smc_n_cs,
  output logic                     smc_n_rd,
  output logic                     smc_n_wr,
  output smc_emi_pkg::emi_lanes_t  smc_n_we,
  output smc_emi_pkg::emi_lanes_t  smc_n_be,
  output logic                     smc_n_ext_oe,
  output smc_emi_pkg::emi_data_t   rdata
);

  import smc_emi_pkg::*;

  logic active;     // Any phase but IDLE
  logic strobe;     // Wait state window
  logic capture;    // Take data_smc this cycle

  assign active = (phase != PH_IDLE);
  assign strobe = (phase == PH_STROBE);

  //--------------------------------------------------------------------
  // Control outputs, one cycle behind phase
  //--------------------------------------------------------------------
  always_ff @(posedge hclk or negedge arst_n) begin
    if (!arst_n) begin
      smc_n_cs     <= 1'b1;
      smc_n_rd     <= 1'b1;
      smc_n_wr     <= 1'b1;
      smc_n_we     <= '1;
      smc_n_be     <= '1;
      smc_n_ext_oe <= 1'b1;
    end else begin
      smc_n_cs     <= ~active;
      smc_n_rd     <= ~(strobe && !wr);
      smc_n_wr     <= ~(strobe && wr);
      smc_n_we     <= ~({EMI_LANES{strobe && wr}} & acc_lanes); // Active lanes only
      smc_n_be     <= active ? ~acc_lanes : '1;                 // Same for reads
      smc_n_ext_oe <= ~(active && wr);  // Drive bus for whole write access
    end
  end

  // Address and write data follow the access, held while idle
  always_ff @(posedge hclk) begin
    if (active) begin
      smc_addr <= acc_addr;
    end
    if (active && wr) begin
      smc_data <= acc_wdata;
    end
  end

  //--------------------------------------------------------------------
  // Read capture
  //--------------------------------------------------------------------
  // Last cycle the registered read strobe is low, which is the first
  // TRAIL cycle. Without trail time take it on done instead
  assign capture = !wr &&
                   (((phase == PH_TRAIL) && !smc_n_rd) ||
                    (done && strobe));

  always_ff @(posedge hclk) begin
    if (capture) begin
      rdata <= data_smc;     // Held until the next read
    end
  end

endmodule

/* hw/smc_lite.sv */
/*
 * Static memory controller top level, AHB-lite slave
 * Slave front end, access sequencer and external drivers
 */

`timescale 1ns/1ps

module smc_lite #(
  parameter int unsigned CSLE_CYCLES = 1,
  parameter int unsigned WS_CYCLES   = 2,
  parameter int unsigned CSTE_CYCLES = 1
) (
  input  logic                    hclk,
  input  logic                    arst_n,
  // AHB-lite
  input  logic                    hsel,
  input  smc_ahb_pkg::htrans_e    htrans,
  input  smc_ahb_pkg::ahb_addr_t  haddr,
  input  logic                    hwrite,
  input  smc_ahb_pkg::hsize_e     hsize,
  input  smc_ahb_pkg::ahb_data_t  hwdata,
  input  logic                    hready,
  output logic                    smc_hready,
  output smc_ahb_pkg::ahb_data_t  smc_hrdata,
  // External memory
  input  smc_emi_pkg::emi_data_t  data_smc,
  output smc_emi_pkg::emi_addr_t  smc_addr,
  output smc_emi_pkg::emi_data_t  smc_data,
  output logic                    smc_n_cs,
  output logic                    smc_n_rd,
  output logic                    smc_n_wr,
  output smc_emi_pkg::emi_lanes_t smc_n_we,
  output smc_emi_pkg::emi_lanes_t smc_n_be,
  output logic                    smc_n_ext_oe
);

  import smc_ahb_pkg::*;
  import smc_emi_pkg::*;

  logic        start;      // Access request pulse
  logic        done;       // End of access
  logic        wr;
  ahb_addr_t   acc_addr;
  byte_lanes_t acc_lanes;
  ahb_data_t   acc_wdata;
  emi_data_t   rdata;
  smc_phase_e  phase;

  smc_ahb_slave i_ahb_slave (
    .hclk, .arst_n, .hsel, .htrans, .haddr, .hwrite, .hsize, .hwdata, .hready,
    .smc_hready, .smc_hrdata, .done, .rdata,
    .start, .wr, .acc_addr, .acc_lanes, .acc_wdata
  );

  smc_access_fsm #(
    .CSLE_CYCLES (CSLE_CYCLES),
    .WS_CYCLES   (WS_CYCLES),
    .CSTE_CYCLES (CSTE_CYCLES)
  ) i_access_fsm (
    .hclk, .arst_n, .start, .phase, .done
  );

  smc_emi_drive i_emi_drive (
    .hclk, .arst_n, .phase, .done, .wr, .acc_addr, .acc_lanes, .acc_wdata,
    .data_smc, .smc_addr, .smc_data, .smc_n_cs, .smc_n_rd, .smc_n_wr,
    .smc_n_we, .smc_n_be, .smc_n_ext_oe, .rdata
  );

endmodule

/* dv/smc_lite_asserts.sv */
/*
 * Concurrent checks on the external strobes, bound into smc_lite
 */

`timescale 1ns/1ps

module smc_lite_asserts (
  input logic                    hclk,
  input logic                    arst_n,
  input logic                    smc_n_cs,
  input logic                    smc_n_rd,
  input logic                    smc_n_wr,
  input smc_emi_pkg::emi_lanes_t smc_n_we,
  input logic                    smc_n_ext_oe
);

  import smc_emi_pkg::*;

  int unsigned assert_errors = 0;   // Summed into the testbench result

  // Read and write strobes are exclusive
  a_rd_wr_excl: assert property (@(posedge hclk) disable iff (!arst_n)
    !(!smc_n_rd && !smc_n_wr))
    else begin
      $error("read and write strobes low together");
      assert_errors++;
    end

  // Strobes only inside chip select
  a_strobe_in_cs: assert property (@(posedge hclk) disable iff (!arst_n)
    smc_n_cs |-> (smc_n_rd && smc_n_wr && (smc_n_we == {EMI_LANES{1'b1}})))
    else begin
      $error("strobe low while chip select is high");
      assert_errors++;
    end

  // Memory drives the bus on reads
  a_no_oe_on_rd: assert property (@(posedge hclk) disable iff (!arst_n)
    !smc_n_rd |-> smc_n_ext_oe)
    else begin
      $error("output enable low during a read");
      assert_errors++;
    end

endmodule

bind smc_lite smc_lite_asserts smc_lite_asserts_i (.*);

/* dv/tb_smc_lite.sv */
/*
 * Testbench for the AHB-lite static memory controller
 * Clock, reset, random AHB master, external memory model,
 * scoreboard, compare tasks and result summary
 */

`timescale 1ns/1ps

module tb_smc_lite;

  import smc_ahb_pkg::*;
  import smc_emi_pkg::*;

  localparam int unsigned CSLE = 1;
  localparam int unsigned WS   = 2;
  localparam int unsigned CSTE = 1;
  localparam int L          = CSLE + WS + CSTE + 2;   // hready low cycles per access
  localparam int CS_LOW     = CSLE + WS + 1 + CSTE;   // Chip select width
  localparam int N_RAND     = 200;
  localparam int N_XFER     = N_RAND + 2;             // Plus directed write and read
  localparam int MAX_CYCLES = N_RAND * (L + 4) + 100;
  localparam ahb_addr_t BASE = 32'h6000_0000;

  logic        hclk, arst_n, hsel, hwrite, hready, smc_hready;
  htrans_e     htrans;
  hsize_e      hsize;
  ahb_addr_t   haddr;
  ahb_data_t   hwdata, smc_hrdata;
  emi_data_t   data_smc, smc_data;
  emi_addr_t   smc_addr;
  logic        smc_n_cs, smc_n_rd, smc_n_wr, smc_n_ext_oe;
  emi_lanes_t  smc_n_we, smc_n_be;

  emi_data_t   mem [64];          // External memory
  ahb_data_t   sb  [64];          // Expected memory contents
  int          checks [5];
  int          errs   [5];
  string       names  [5];
  int          cycle_cnt, n_issued, n_done, total, n_checks;
  // Address phase on the bus
  int          p_kind;            // 0 transfer, 1 hsel low, 2 IDLE, 3 BUSY
  int          p_num;
  logic        p_valid, p_wr;
  htrans_e     p_trans;
  hsize_e      p_size;
  ahb_addr_t   p_addr;
  ahb_data_t   p_data;
  // Access in its data phase
  logic        f_busy, f_first, f_wr, ign_prev, hr;
  int          f_num, f_low, f_cs;
  int          f_rd, f_wrs, f_oe; // Cycles with each strobe low
  logic [5:0]  f_idx;
  byte_lanes_t f_lanes;
  ahb_data_t   f_data;

  smc_lite #(
    .CSLE_CYCLES (CSLE),
    .WS_CYCLES   (WS),
    .CSTE_CYCLES (CSTE)
  ) smc_lite_i (.*);

  assign hready = smc_hready;     // Single slave on the bus

  //--------------------------------------------------------------------
  // External memory model
  //--------------------------------------------------------------------
  assign data_smc = (smc_n_rd === 1'b0) ? mem[smc_addr[7:2]] : '0;

  always @(posedge hclk) begin
    for (int b = 0; b < 4; b++) begin
      if (smc_n_we[b] === 1'b0) begin
        mem[smc_addr[7:2]][8*b +: 8] <= smc_data[8*b +: 8];  // Active lanes only
      end
    end
  end

  initial begin
    hclk = 1'b0;
    forever #5 hclk = ~hclk;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge hclk);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles with %0d of %0d transfers done",
             cycle_cnt, n_done, N_XFER);
    $display("TEST FAILED");
    $finish;
  end

  //--------------------------------------------------------------------
  // Expected values
  //--------------------------------------------------------------------
  // Word pattern built from every bit of the word index
  function automatic emi_data_t fill_word(input logic [5:0] idx);
    return {idx, 2'b01, ~idx, 2'b10, idx ^ 6'h2a, 2'b11, 2'b00, idx};
  endfunction

  function automatic byte_lanes_t expect_lanes(input logic [1:0] lo, input hsize_e size);
    byte_lanes_t ln;
    ln = '0;
    if (size == HSIZE_WORD) begin
      ln = 4'hf;
    end else if (size == HSIZE_HALF) begin
      ln[lo[1]*2 +: 2] = 2'b11;     // Lower or upper halfword
    end else begin
      ln[lo] = 1'b1;
    end
    return ln;
  endfunction

  function automatic ahb_data_t merge_lanes(input ahb_data_t old_w, input ahb_data_t new_w,
                                            input byte_lanes_t ln);
    ahb_data_t m;
    m = old_w;
    for (int b = 0; b < 4; b++) begin
      if (ln[b]) begin
        m[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return m;
  endfunction

  //--------------------------------------------------------------------
  // Compare and report tasks
  //--------------------------------------------------------------------
  task automatic check_data(input int t, input ahb_data_t exp, input ahb_data_t act);
    checks[t]++;
    if (act !== exp) begin
      errs[t]++;
      $display("mismatch %s: expected %h, actual %h", names[t], exp, act);
    end
  endtask

  task automatic check_lanes(input int t, input byte_lanes_t exp, input byte_lanes_t act);
    checks[t]++;
    if (act !== exp) begin
      errs[t]++;
      $display("mismatch %s: expected %b, actual %b", names[t], exp, act);
    end
  endtask

  task automatic check_count(input int t, input int exp, input int act);
    checks[t]++;
    if (act != exp) begin
      errs[t]++;
      $display("mismatch %s: expected %0d, actual %0d", names[t], exp, act);
    end
  endtask

  task automatic expect_true(input int t, input logic ok, input string what);
    checks[t]++;
    if (ok !== 1'b1) begin
      errs[t]++;
      $display("error %s: %s", names[t], what);
    end
  endtask

  task automatic report_test(input int t);
    $display("%-11s %0d checks, %0d errors, %s", names[t], checks[t], errs[t],
             (errs[t] == 0) ? "passed" : "failed");
  endtask

  //--------------------------------------------------------------------
  // AHB master
  //--------------------------------------------------------------------
  task automatic pick_next();
    logic [5:0] idx;
    logic [1:0] off;
    idx     = 6'($urandom_range(63));
    p_wr    = 1'($urandom_range(1));
    p_data  = ahb_data_t'($urandom);
    p_trans = ($urandom_range(1) == 1) ? HTRANS_SEQ : HTRANS_NONSEQ;
    p_size  = hsize_e'($urandom_range(2));
    off     = (p_size == HSIZE_BYTE) ? 2'($urandom_range(3)) :
              (p_size == HSIZE_HALF) ? 2'($urandom_range(1) * 2) : 2'b00;
    p_kind  = 0;
    if (n_issued < 2) begin               // Directed word write and its read back
      p_size = HSIZE_WORD;
      p_wr   = (n_issued == 0);
      idx    = 6'd5;
      off    = 2'b00;
    end else if (n_issued == N_XFER || $urandom_range(3) == 0) begin
      p_kind = 1 + int'($urandom_range(2)); // Gap cycle
    end
    p_addr  = BASE + {24'h0, idx, off};
    p_num   = n_issued;
    p_valid = 1'b1;
    if (p_kind == 0) begin
      n_issued++;
    end
  endtask

  task automatic start_access();
    f_busy  = 1'b1;
    f_first = 1'b1;
    f_low   = 0;
    f_cs    = 0;
    f_rd    = 0;
    f_wrs   = 0;
    f_oe    = 0;
    f_num   = p_num;
    f_wr    = p_wr;
    f_data  = p_data;
    f_idx   = p_addr[7:2];
    f_lanes = expect_lanes(p_addr[1:0], p_size);
  endtask

  task automatic end_access();
    check_count(3, L, f_low);
    check_count(3, CS_LOW, f_cs);
    check_count(3, f_wr ? 0 : WS + 1, f_rd);      // Read strobe spans the wait window
    check_count(3, f_wr ? WS + 1 : 0, f_wrs);
    check_count(3, f_wr ? CS_LOW : 0, f_oe);      // Bus driven for the whole write
    if (f_wr) begin
      sb[f_idx] = merge_lanes(sb[f_idx], f_data, f_lanes);
    end else begin
      check_data((f_num < 2) ? 1 : 2, sb[f_idx], smc_hrdata);
    end
    if (f_num == 1) begin
      report_test(1);
    end
    n_done++;
    f_busy = 1'b0;
  endtask

  initial begin
    void'($urandom(32'he2e7));
    names    = '{"reset", "word_wr_rd", "partial_wr", "latency", "ignored"};
    checks   = '{default: 0};
    errs     = '{default: 0};
    arst_n   = 1'b0;
    hsel     = 1'b0;
    htrans   = HTRANS_IDLE;
    haddr    = '0;
    hwrite   = 1'b0;
    hsize    = HSIZE_WORD;
    hwdata   = '0;
    p_valid  = 1'b0;
    f_busy   = 1'b0;
    f_first  = 1'b0;
    ign_prev = 1'b0;
    n_issued = 0;
    n_done   = 0;
    for (int i = 0; i < 64; i++) begin
      mem[i] = fill_word(6'(i));
      sb[i]  = fill_word(6'(i));
    end
    repeat (16) @(posedge hclk);
    #1 arst_n = 1'b1;
    expect_true(0, {smc_n_cs, smc_n_rd, smc_n_wr, smc_n_ext_oe, smc_hready} === 5'h1f,
                "chip select, a strobe, output enable or hready is low after reset");
    check_lanes(0, 4'hf, smc_n_we);
    check_lanes(0, 4'hf, smc_n_be);
    report_test(0);

    // One pass per cycle 1 ns after the edge
    while (n_done < N_XFER) begin
      @(posedge hclk);
      #1;
      hr = smc_hready;                    // Applies at the next edge
      if (ign_prev) begin
        expect_true(4, smc_n_cs === 1'b1 && hr === 1'b1, "ignored cycle started an access");
        ign_prev = 1'b0;
      end
      if (f_busy) begin
        if (f_first) begin
          hwdata  = f_wr ? f_data : ahb_data_t'($urandom);  // First data phase cycle
          f_first = 1'b0;
        end
        if (smc_n_cs === 1'b0) begin
          f_cs++;
          check_lanes(2, ~f_lanes, smc_n_be);
        end
        if (smc_n_rd === 1'b0) begin
          f_rd++;
        end
        if (smc_n_wr === 1'b0) begin
          f_wrs++;
        end
        if (smc_n_ext_oe === 1'b0) begin
          f_oe++;
        end
        if (hr === 1'b0) begin
          f_low++;
        end else begin
          end_access();
        end
      end
      if (!p_valid) begin
        pick_next();
      end
      hsel   = (p_kind != 1);
      htrans = (p_kind == 2) ? HTRANS_IDLE : (p_kind == 3) ? HTRANS_BUSY : p_trans;
      haddr  = p_addr;
      hwrite = p_wr;
      hsize  = p_size;
      if (hr === 1'b1) begin              // Held while hready is low
        if (p_kind == 0) begin
          start_access();
        end else begin
          ign_prev = 1'b1;
        end
        p_valid = 1'b0;
      end
    end

    for (int t = 2; t < 5; t++) begin
      report_test(t);
    end
    total    = smc_lite_i.smc_lite_asserts_i.assert_errors;
    n_checks = 0;
    for (int t = 0; t < 5; t++) begin
      total    += errs[t];
      n_checks += checks[t];
    end
    $display("summary: %0d transfers, %0d checks, %0d errors, %0d assertion failures",
             n_done, n_checks, total, smc_lite_i.smc_lite_asserts_i.assert_errors);
    if (total == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* sim.f */
hw/smc_ahb_pkg.sv
hw/smc_emi_pkg.sv
hw/smc_ahb_slave.sv
hw/smc_access_fsm.sv
hw/smc_emi_drive.sv
hw/smc_lite.sv
dv/smc_lite_asserts.sv
dv/tb_smc_lite.sv

/* Bender.yml */
package:
  name: smc_lite

sources:
  # Packages first, then RTL bottom up
  - hw/smc_ahb_pkg.sv
  - hw/smc_emi_pkg.sv
  - hw/smc_ahb_slave.sv
  - hw/smc_access_fsm.sv
  - hw/smc_emi_drive.sv
  - hw/smc_lite.sv
  - target: simulation
    files:
      - dv/smc_lite_asserts.sv
      - dv/tb_smc_lite.sv
